// ==== run.sh ====
#!/bin/sh
# Build the branch predictor testbench with Verilator, run it, check the log.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tbBranchPredict -f tb.f -o simBranchPredict
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/simBranchPredict > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TB PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== tb.f ====
verilog/bpConfigPkg.sv
verilog/bpTypesPkg.sv
verilog/directMapTable.sv
verilog/bhtBank.sv
verilog/updateReceiver.sv
verilog/returnStack.sv
verilog/targetBuffer.sv
verilog/nextPcSelect.sv
verilog/branchPredictUnit.sv
tests/branchPredict_chk.sv
tests/tbBranchPredict.sv

// ==== tests/branchPredict_chk.sv ====
/*
 * Handshake assertions for the update receiver, attached by bind.
 * Covers req/ack ordering and one write cycle per handshake.
 */
`timescale 1ns/1ps
`default_nettype none

module branchPredictChk (
    input logic                                              clk,
    input logic                                              resetn,
    input logic                                              updateReq,
    input logic                                              updateAck,
    input bpTypesPkg::bankWriteT [bpConfigPkg::bhtBanks-1:0] bankWrite,
    input logic                                              btbWrEn,
    input logic                                              rasPush,
    input logic                                              rasPop
);

    int   assertFailures = 0;
    logic anyWrite;

    always_comb begin
        anyWrite = btbWrEn | rasPush | rasPop;
        for (int b = 0; b < bpConfigPkg::bhtBanks; b++) begin
            anyWrite = anyWrite | bankWrite[b].en;
        end
    end

    ackNeedsReq: assert property (@(posedge clk) disable iff (!resetn)
        $rose(updateAck) |-> $past(updateReq))
        else begin
            assertFailures++;
            $error("updateAck rose without updateReq");
        end

    // the requester may drop req only once ack is back
    reqHeldUntilAck: assert property (@(posedge clk) disable iff (!resetn)
        $fell(updateReq) |-> updateAck)
        else begin
            assertFailures++;
            $error("updateReq fell before updateAck was high");
        end

    singleWriteCycle: assert property (@(posedge clk) disable iff (!resetn)
        anyWrite |=> !anyWrite)
        else begin
            assertFailures++;
            $error("write strobes active for more than one cycle");
        end

endmodule

bind updateReceiver branchPredictChk u_chk (
    .clk       (clk),
    .resetn    (resetn),
    .updateReq (updateReq),
    .updateAck (updateAck),
    .bankWrite (bankWrite),
    .btbWrEn   (btbWrEn),
    .rasPush   (rasPush),
    .rasPop    (rasPop)
);

`default_nettype wire

// ==== tests/tbBranchPredict.sv ====
/*
 * Directed testbench for the branch prediction unit. A reference model
 * tracks counters, BTB and return stack and predicts every lookup.
 */
`timescale 1ns/1ps
`default_nettype none

module tbBranchPredict;

    localparam int clkPeriod = 100;
    localparam int handshakeLimit = 20;
    // roughly 300 handshakes at up to 6 cycles each, with margin
    localparam int timeoutCycles = 4000;

    logic                   clk;
    logic                   resetn;
    logic [31:0]            fetchPc;
    bpTypesPkg::predictionT prediction;
    bpTypesPkg::updateT     update;
    logic                   updateReq;
    logic                   updateAck;

    logic [31:0] rngState;
    int          cycleCount = 0;

    // reference model state
    logic [1:0]             refCounter [256];
    logic                   refValid [128];
    logic [22:0]            refTag [128];
    bpTypesPkg::branchKindT refKind [128];
    logic [31:0]            refTarget [128];
    logic [31:0]            refStack [32];
    logic [4:0]             refPtr;

    branchPredictUnit u_dut (
        .clk        (clk),
        .resetn     (resetn),
        .fetchPc    (fetchPc),
        .prediction (prediction),
        .update     (update),
        .updateReq  (updateReq),
        .updateAck  (updateAck)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            abortRun($sformatf("Timeout: run did not finish within %0d cycles", timeoutCycles));
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic checkEq(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("Fail at %0t ns: %s is %h, expected %h",
                               $time, name, actual, expected));
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic bpTypesPkg::updateT makeUpdate(input logic [31:0] pc, input logic taken,
            input logic uncond, input bpTypesPkg::branchKindT kind, input logic [31:0] target);
        bpTypesPkg::updateT u;
        u.pc     = pc;
        u.taken  = taken;
        u.uncond = uncond;
        u.kind   = kind;
        u.target = target;
        return u;
    endfunction

    task automatic resetModel();
        for (int i = 0; i < 256; i++) begin
            refCounter[i] = 2'b00;
        end
        for (int i = 0; i < 128; i++) begin
            refValid[i]  = 1'b0;
            refTag[i]    = '0;
            refKind[i]   = bpTypesPkg::kindNone;
            refTarget[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            refStack[i] = '0;
        end
        refPtr = '0;
    endtask

    task automatic applyModel(input bpTypesPkg::updateT u);
        logic [7:0] idx;
        logic [6:0] bi;
        idx = u.pc[9:2];
        bi  = u.pc[8:2];
        if (u.uncond) begin
            refCounter[idx] = 2'b11;
        end else if (u.taken && refCounter[idx] != 2'b11) begin
            refCounter[idx] = refCounter[idx] + 2'd1;
        end else if (!u.taken && refCounter[idx] != 2'b00) begin
            refCounter[idx] = refCounter[idx] - 2'd1;
        end
        if (u.taken && u.kind != bpTypesPkg::kindNone) begin
            refValid[bi]  = 1'b1;
            refTag[bi]    = u.pc[31:9];
            refKind[bi]   = u.kind;
            refTarget[bi] = (u.kind == bpTypesPkg::kindReturn) ? 32'd0 : u.target;
            if (u.kind == bpTypesPkg::kindCall) begin
                refStack[refPtr] = u.pc + 32'd8;
                refPtr = refPtr + 5'd1;
            end else if (u.kind == bpTypesPkg::kindReturn) begin
                refPtr = refPtr - 5'd1;
            end
        end
    endtask

    function automatic bpTypesPkg::predictionT modelPredict(input logic [31:0] pc);
        bpTypesPkg::predictionT p;
        logic [6:0] bi;
        logic [4:0] topIdx;
        bi     = pc[8:2];
        topIdx = refPtr - 5'd1;
        p.taken  = refCounter[pc[9:2]][1];
        p.hit    = refValid[bi] && (refTag[bi] == pc[31:9]);
        p.nextPc = pc + 32'd4;
        if (p.hit && p.taken) begin
            if (refKind[bi] == bpTypesPkg::kindJump || refKind[bi] == bpTypesPkg::kindCall) begin
                p.nextPc = refTarget[bi];
            end else if (refKind[bi] == bpTypesPkg::kindReturn) begin
                p.nextPc = refStack[topIdx];
            end
        end
        return p;
    endfunction

    // full four-phase handshake, model updated once it completes
    task automatic doUpdate(input bpTypesPkg::updateT u);
        int waitCycles;
        @(negedge clk);
        update    = u;
        updateReq = 1'b1;
        waitCycles = 0;
        while (!updateAck) begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > handshakeLimit) begin
                abortRun("updateAck never rose after updateReq was raised");
            end
        end
        updateReq = 1'b0;
        waitCycles = 0;
        while (updateAck) begin
            @(negedge clk);
            waitCycles++;
            if (waitCycles > handshakeLimit) begin
                abortRun("updateAck stayed high after updateReq was lowered");
            end
        end
        applyModel(u);
    endtask

    task automatic lookup(input logic [31:0] pc);
        @(negedge clk);
        fetchPc = pc;
        #(clkPeriod / 4);
    endtask

    task automatic checkPrediction(input logic [31:0] pc);
        bpTypesPkg::predictionT expected;
        expected = modelPredict(pc);
        checkEq("prediction", 64'(prediction), 64'(expected));
    endtask

    task automatic checkAfterReset();
        logic [31:0] pcs [4];
        pcs = '{32'h0000_0000, 32'h0000_0104, 32'h0000_03fc, 32'hffff_fff0};
        checkEq("updateAck", 64'(updateAck), 64'(0));
        foreach (pcs[i]) begin
            lookup(pcs[i]);
            checkEq("prediction.taken", 64'(prediction.taken), 64'(0));
            checkEq("prediction.hit", 64'(prediction.hit), 64'(0));
            checkEq("prediction.nextPc", 64'(prediction.nextPc), 64'(pcs[i] + 32'd4));
        end
    endtask

    task automatic checkCounterSaturation();
        logic [31:0] pc;
        logic [31:0] target;
        logic [5:0]  expTaken;
        pc       = 32'h0000_0208;
        target   = 32'h0000_4000;
        // counter walks 1,2,3 then 2,1,0
        expTaken = 6'b001110;
        for (int i = 0; i < 6; i++) begin
            doUpdate(makeUpdate(pc, (i < 3), 1'b0, bpTypesPkg::kindJump, target));
            lookup(pc);
            checkEq("prediction.taken", 64'(prediction.taken), 64'(expTaken[i]));
            checkEq("prediction.nextPc", 64'(prediction.nextPc),
                    64'(expTaken[i] ? target : pc + 32'd4));
            checkPrediction(pc);
        end
    endtask

    task automatic checkTagAliasing();
        logic [31:0] pcA;
        logic [31:0] pcB;
        pcA = 32'h0000_0110;
        // same BTB index and counter, different tag
        pcB = 32'h0000_1110;
        doUpdate(makeUpdate(pcA, 1'b1, 1'b1, bpTypesPkg::kindJump, 32'h0000_8000));
        lookup(pcA);
        checkEq("prediction.hit", 64'(prediction.hit), 64'(1));
        checkEq("prediction.nextPc", 64'(prediction.nextPc), 64'(32'h0000_8000));
        lookup(pcB);
        checkEq("prediction.hit", 64'(prediction.hit), 64'(0));
        checkEq("prediction.taken", 64'(prediction.taken), 64'(1));
        checkEq("prediction.nextPc", 64'(prediction.nextPc), 64'(pcB + 32'd4));
        checkPrediction(pcB);
    endtask

    task automatic checkCallReturn(input logic [31:0] retPc);
        logic [31:0] callPc;
        // train the return PC first so every later return hits
        doUpdate(makeUpdate(retPc, 1'b1, 1'b1, bpTypesPkg::kindReturn, 32'h0));
        for (int k = 0; k < 4; k++) begin
            callPc = 32'h0000_3010 + 32'(16 * k);
            doUpdate(makeUpdate(callPc, 1'b1, 1'b1, bpTypesPkg::kindCall, 32'h0000_6000));
        end
        for (int k = 3; k >= 0; k--) begin
            lookup(retPc);
            checkEq("prediction.nextPc", 64'(prediction.nextPc),
                    64'(32'h0000_3010 + 32'(16 * k) + 32'd8));
            checkPrediction(retPc);
            doUpdate(makeUpdate(retPc, 1'b1, 1'b1, bpTypesPkg::kindReturn, 32'h0));
        end
    endtask

    task automatic checkStackWrap(input logic [31:0] retPc);
        for (int k = 0; k < 33; k++) begin
            doUpdate(makeUpdate(32'h0001_0000 + 32'(16 * k), 1'b1, 1'b1,
                                bpTypesPkg::kindCall, 32'h0000_7000));
        end
        // the first call was overwritten, so pops stop at the second one
        for (int k = 32; k >= 1; k--) begin
            lookup(retPc);
            checkEq("prediction.nextPc", 64'(prediction.nextPc),
                    64'(32'h0001_0000 + 32'(16 * k) + 32'd8));
            doUpdate(makeUpdate(retPc, 1'b1, 1'b1, bpTypesPkg::kindReturn, 32'h0));
        end
    endtask

    task automatic checkRandomUpdates();
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] target;
        for (int n = 0; n < 200; n++) begin
            rngState = xorshift(rngState);
            pc = 32'h0000_4000 | (rngState & 32'h0000_0ffc);
            rngState = xorshift(rngState);
            target = rngState & 32'hffff_fffc;
            rngState = xorshift(rngState);
            r = rngState;
            doUpdate(makeUpdate(pc, r[2], r[3] & r[4], bpTypesPkg::branchKindT'(r[1:0]), target));
            rngState = xorshift(rngState);
            pc = 32'h0000_4000 | (rngState & 32'h0000_0ffc);
            lookup(pc);
            checkPrediction(pc);
        end
    endtask

    initial begin
        resetn    = 1'b0;
        fetchPc   = '0;
        update    = '0;
        updateReq = 1'b0;
        rngState  = 32'h74751d72;
        resetModel();
        repeat (2) @(negedge clk);
        resetn = 1'b1;

        checkAfterReset();
        checkCounterSaturation();
        checkTagAliasing();
        checkCallReturn(32'h0000_3084);
        checkStackWrap(32'h0000_3084);
        checkRandomUpdates();

        @(negedge clk);
        if (u_dut.u_receiver.u_chk.assertFailures == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            abortRun("a handshake assertion failed during the run");
        end
    end

endmodule

`default_nettype wire

// ==== verilog/bhtBank.sv ====
/*
 * One bank of two-bit direction counters. Lookup gives the counter MSB,
 * a write command applies the saturating or unconditional rule.
 */
`timescale 1ns/1ps
`default_nettype none

module bhtBank (
    input  logic                              clk,
    input  logic                              resetn,
    input  logic [bpConfigPkg::slotWidth-1:0] lookupSlot,
    output logic                              counterMsb,
    input  bpTypesPkg::bankWriteT             write
);

    logic [bpConfigPkg::slotWidth-1:0] rdSlot;
    bpTypesPkg::counterT               current;
    bpTypesPkg::counterT               nextCounter;

    // the update slot borrows the read port for its write cycle
    assign rdSlot = write.en ? write.slot : lookupSlot;

    directMapTable #(
        .entryT     (bpTypesPkg::counterT),
        .depth      (bpConfigPkg::bankDepth),
        .resetValue (bpTypesPkg::strongNot)
    ) u_table (
        .clk     (clk),
        .resetn  (resetn),
        .rdIndex (rdSlot),
        .rdData  (current),
        .wrEn    (write.en),
        .wrIndex (write.slot),
        .wrData  (nextCounter)
    );

    always_comb begin
        if (write.uncond) begin
            nextCounter = bpTypesPkg::strongTaken;
        end else if (write.taken) begin
            nextCounter = (current == bpTypesPkg::strongTaken) ? bpTypesPkg::strongTaken
                        : bpTypesPkg::counterT'(current + 2'd1);
        end else begin
            nextCounter = (current == bpTypesPkg::strongNot) ? bpTypesPkg::strongNot
                        : bpTypesPkg::counterT'(current - 2'd1);
        end
    end

    // upper bit says taken
    assign counterMsb = current[1];

endmodule

`default_nettype wire

// ==== verilog/bpConfigPkg.sv ====
/*
 * Table sizes and PC bit positions for the branch predictor.
 * Modules refer to these by scoped name.
 */
`default_nettype none

package bpConfigPkg;

    localparam int pcWidth     = 32;
    localparam int bhtEntries  = 256;
    localparam int bhtBanks    = 4;
    localparam int bankDepth   = bhtEntries / bhtBanks;
    localparam int btbEntries  = 128;
    localparam int btbTagWidth = 23;
    localparam int rasDepth    = 32;
    localparam int rasPtrWidth = 5;

    // direction table: bank from pc[3:2], slot from pc[9:4]
    localparam int bankSelLsb    = 2;
    localparam int bankSelWidth  = $clog2(bhtBanks);
    localparam int slotLsb       = bankSelLsb + bankSelWidth;
    localparam int slotWidth     = $clog2(bankDepth);

    // target buffer: index pc[8:2], tag pc[31:9]
    localparam int btbIndexLsb   = 2;
    localparam int btbIndexWidth = $clog2(btbEntries);
    localparam int btbTagLsb     = btbIndexLsb + btbIndexWidth;

endpackage

`default_nettype wire

// ==== verilog/bpTypesPkg.sv ====
/*
 * Branch kinds, counter encoding and the structs passed between
 * the predictor blocks.
 */
`default_nettype none

package bpTypesPkg;

    typedef enum logic [1:0] {
        kindNone   = 2'b00,
        kindReturn = 2'b01,
        kindJump   = 2'b10,
        kindCall   = 2'b11
    } branchKindT;

    // two-bit saturating direction counter
    typedef enum logic [1:0] {
        strongNot   = 2'b00,
        weakNot     = 2'b01,
        weakTaken   = 2'b10,
        strongTaken = 2'b11
    } counterT;

    typedef struct packed {
        logic                                 valid;
        logic [bpConfigPkg::btbTagWidth-1:0]  tag;
        branchKindT                           kind;
        logic [bpConfigPkg::pcWidth-1:0]      target;
    } btbEntryT;

    // resolved branch from execute
    typedef struct packed {
        logic [bpConfigPkg::pcWidth-1:0] pc;
        logic                            taken;
        logic                            uncond;
        branchKindT                      kind;
        logic [bpConfigPkg::pcWidth-1:0] target;
    } updateT;

    typedef struct packed {
        logic                            taken;
        logic                            hit;
        logic [bpConfigPkg::pcWidth-1:0] nextPc;
    } predictionT;

    // one-cycle write command into a single direction bank
    typedef struct packed {
        logic                              en;
        logic [bpConfigPkg::slotWidth-1:0] slot;
        logic                              taken;
        logic                              uncond;
    } bankWriteT;

endpackage

`default_nettype wire

// ==== verilog/branchPredictUnit.sv ====
/*
 * Branch prediction unit top level. Prediction follows fetchPc
 * combinationally; updates arrive over the req/ack channel.
 */
`timescale 1ns/1ps
`default_nettype none

module branchPredictUnit (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic [bpConfigPkg::pcWidth-1:0] fetchPc,
    output bpTypesPkg::predictionT          prediction,
    input  bpTypesPkg::updateT              update,
    input  logic                            updateReq,
    output logic                            updateAck
);

    bpTypesPkg::bankWriteT [bpConfigPkg::bhtBanks-1:0] bankWrite;
    logic [bpConfigPkg::bhtBanks-1:0]      bankMsb;
    logic                                  btbWrEn;
    logic [bpConfigPkg::btbIndexWidth-1:0] btbWrIndex;
    bpTypesPkg::btbEntryT                  btbWrData;
    bpTypesPkg::btbEntryT                  btbEntry;
    logic                                  btbHit;
    logic                                  rasPush;
    logic                                  rasPop;
    logic [bpConfigPkg::pcWidth-1:0]       rasPushData;
    logic [bpConfigPkg::pcWidth-1:0]       rasTop;

    updateReceiver u_receiver (
        .clk(clk), .resetn(resetn),
        .update(update), .updateReq(updateReq), .updateAck(updateAck),
        .bankWrite(bankWrite),
        .btbWrEn(btbWrEn), .btbWrIndex(btbWrIndex), .btbWrData(btbWrData),
        .rasPush(rasPush), .rasPop(rasPop), .rasPushData(rasPushData)
    );

    // every bank looks up the same slot, the selector picks one
    for (genvar b = 0; b < bpConfigPkg::bhtBanks; b++) begin : gBank
        bhtBank u_bank (
            .clk        (clk),
            .resetn     (resetn),
            .lookupSlot (fetchPc[bpConfigPkg::slotLsb +: bpConfigPkg::slotWidth]),
            .counterMsb (bankMsb[b]),
            .write      (bankWrite[b])
        );
    end

    targetBuffer u_btb (
        .clk(clk), .resetn(resetn),
        .lookupPc(fetchPc), .hit(btbHit), .entry(btbEntry),
        .wrEn(btbWrEn), .wrIndex(btbWrIndex), .wrData(btbWrData)
    );

    returnStack u_ras (
        .clk(clk), .resetn(resetn),
        .push(rasPush), .pop(rasPop), .pushData(rasPushData), .top(rasTop)
    );

    nextPcSelect u_select (
        .fetchPc(fetchPc), .bankMsb(bankMsb), .btbHit(btbHit),
        .btbEntry(btbEntry), .rasTop(rasTop), .prediction(prediction)
    );

endmodule

`default_nettype wire

// ==== verilog/directMapTable.sv ====
/*
 * Indexed storage with a combinational read and a clocked write.
 * The entry type is a parameter, so banks and the BTB share it.
 */
`timescale 1ns/1ps
`default_nettype none

module directMapTable #(
    parameter type entryT = logic [7:0],
    parameter int depth = 16,
    parameter entryT resetValue = entryT'(0)
) (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic [$clog2(depth)-1:0] rdIndex,
    output entryT                    rdData,
    input  logic                     wrEn,
    input  logic [$clog2(depth)-1:0] wrIndex,
    input  entryT                    wrData
);

    entryT mem [depth];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= resetValue;
            end
        end else if (wrEn) begin
            mem[wrIndex] <= wrData;
        end
    end

    assign rdData = mem[rdIndex];

endmodule

`default_nettype wire

// ==== verilog/nextPcSelect.sv ====
/*
 * Combines bank direction bits, the BTB entry and the stack top
 * into the fetch prediction. Purely combinational.
 */
`timescale 1ns/1ps
`default_nettype none

module nextPcSelect (
    input  logic [bpConfigPkg::pcWidth-1:0]  fetchPc,
    input  logic [bpConfigPkg::bhtBanks-1:0] bankMsb,
    input  logic                             btbHit,
    input  bpTypesPkg::btbEntryT             btbEntry,
    input  logic [bpConfigPkg::pcWidth-1:0]  rasTop,
    output bpTypesPkg::predictionT           prediction
);

    logic [bpConfigPkg::bankSelWidth-1:0] bankSel;
    logic                                 dirTaken;

    assign bankSel  = fetchPc[bpConfigPkg::bankSelLsb +: bpConfigPkg::bankSelWidth];
    assign dirTaken = bankMsb[bankSel];

    always_comb begin
        prediction.taken  = dirTaken;
        prediction.hit    = btbHit;
        prediction.nextPc = fetchPc + 32'd4;
        if (btbHit && dirTaken) begin
            case (btbEntry.kind)
                bpTypesPkg::kindJump,
                bpTypesPkg::kindCall:   prediction.nextPc = btbEntry.target;
                bpTypesPkg::kindReturn: prediction.nextPc = rasTop;
                default:                prediction.nextPc = fetchPc + 32'd4;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verilog/returnStack.sv ====
/*
 * Circular return address stack. A push past full overwrites the
 * oldest entry; top is the entry just below the pointer.
 */
`timescale 1ns/1ps
`default_nettype none

module returnStack (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            push,
    input  logic                            pop,
    input  logic [bpConfigPkg::pcWidth-1:0] pushData,
    output logic [bpConfigPkg::pcWidth-1:0] top
);

    logic [bpConfigPkg::pcWidth-1:0]     entries [bpConfigPkg::rasDepth];
    logic [bpConfigPkg::rasPtrWidth-1:0] ptr;
    logic [bpConfigPkg::rasPtrWidth-1:0] topPtr;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ptr <= '0;
            for (int i = 0; i < bpConfigPkg::rasDepth; i++) begin
                entries[i] <= '0;
            end
        end else if (push) begin
            entries[ptr] <= pushData;
            ptr          <= ptr + 1'b1;
        end else if (pop) begin
            // pointer wraps, so popping past empty just walks back
            ptr <= ptr - 1'b1;
        end
    end

    assign topPtr = ptr - 1'b1;
    assign top    = entries[topPtr];

endmodule

`default_nettype wire

// ==== verilog/targetBuffer.sv ====
/*
 * Direct-mapped branch target buffer. Lookup splits the PC into
 * index and tag; hit needs a valid entry with a matching tag.
 */
`timescale 1ns/1ps
`default_nettype none

module targetBuffer (
    input  logic                                  clk,
    input  logic                                  resetn,
    input  logic [bpConfigPkg::pcWidth-1:0]       lookupPc,
    output logic                                  hit,
    output bpTypesPkg::btbEntryT                  entry,
    input  logic                                  wrEn,
    input  logic [bpConfigPkg::btbIndexWidth-1:0] wrIndex,
    input  bpTypesPkg::btbEntryT                  wrData
);

    logic [bpConfigPkg::btbIndexWidth-1:0] lookupIndex;
    logic [bpConfigPkg::btbTagWidth-1:0]   lookupTag;

    assign lookupIndex = lookupPc[bpConfigPkg::btbIndexLsb +: bpConfigPkg::btbIndexWidth];
    assign lookupTag   = lookupPc[bpConfigPkg::btbTagLsb +: bpConfigPkg::btbTagWidth];

    // all entries come out of reset invalid
    directMapTable #(
        .entryT     (bpTypesPkg::btbEntryT),
        .depth      (bpConfigPkg::btbEntries),
        .resetValue ('0)
    ) u_table (
        .clk     (clk),
        .resetn  (resetn),
        .rdIndex (lookupIndex),
        .rdData  (entry),
        .wrEn    (wrEn),
        .wrIndex (wrIndex),
        .wrData  (wrData)
    );

    assign hit = entry.valid && (entry.tag == lookupTag);

endmodule

`default_nettype wire

// ==== verilog/updateReceiver.sv ====
/*
 * Four-phase slave for resolved branches from execute. Each handshake
 * yields one cycle of writes to a bank, the BTB and the return stack.
 */
`timescale 1ns/1ps
`default_nettype none

module updateReceiver (
    input  logic                                          clk,
    input  logic                                          resetn,
    input  bpTypesPkg::updateT                            update,
    input  logic                                          updateReq,
    output logic                                          updateAck,
    output bpTypesPkg::bankWriteT [bpConfigPkg::bhtBanks-1:0] bankWrite,
    output logic                                          btbWrEn,
    output logic [bpConfigPkg::btbIndexWidth-1:0]         btbWrIndex,
    output bpTypesPkg::btbEntryT                          btbWrData,
    output logic                                          rasPush,
    output logic                                          rasPop,
    output logic [bpConfigPkg::pcWidth-1:0]               rasPushData
);

    logic                                newRequest;
    logic [bpConfigPkg::bankSelWidth-1:0] bankSel;

    // req high with ack still low starts a handshake
    assign newRequest = updateReq && !updateAck;

    // ack follows req one edge later, rising on the write edge
    always_ff @(posedge clk) begin
        if (!resetn) begin
            updateAck <= 1'b0;
        end else begin
            updateAck <= updateReq;
        end
    end

    assign bankSel = update.pc[bpConfigPkg::bankSelLsb +: bpConfigPkg::bankSelWidth];

    always_comb begin
        for (int b = 0; b < bpConfigPkg::bhtBanks; b++) begin
            bankWrite[b].en     = newRequest && (int'(bankSel) == b);
            bankWrite[b].slot   = update.pc[bpConfigPkg::slotLsb +: bpConfigPkg::slotWidth];
            bankWrite[b].taken  = update.taken;
            bankWrite[b].uncond = update.uncond;
        end
    end

    // only taken branches of a known kind touch the BTB and stack
    assign btbWrEn    = newRequest && update.taken && (update.kind != bpTypesPkg::kindNone);
    assign btbWrIndex = update.pc[bpConfigPkg::btbIndexLsb +: bpConfigPkg::btbIndexWidth];

    assign btbWrData.valid  = 1'b1;
    assign btbWrData.tag    = update.pc[bpConfigPkg::btbTagLsb +: bpConfigPkg::btbTagWidth];
    assign btbWrData.kind   = update.kind;
    assign btbWrData.target = (update.kind == bpTypesPkg::kindReturn) ? '0 : update.target;

    assign rasPush     = btbWrEn && (update.kind == bpTypesPkg::kindCall);
    assign rasPop      = btbWrEn && (update.kind == bpTypesPkg::kindReturn);
    assign rasPushData = update.pc + 32'd8;

endmodule

`default_nettype wire
